//--- compile.f
hdl/qr_pkg.sv
hdl/dot4_unit.sv
hdl/seq_divider.sv
hdl/projection_unit.sv
hdl/gs_sequencer.sv
hdl/qr_orth_top.sv
verification/tb_qr_orth.sv

//--- hdl/dot4_unit.sv
`timescale 1ns/1ps

// four lane multipliers feeding one adder tree
// result registered, valid one cycle after the operands
module dot4_unit
(
    input  logic          clk_QR_g,
    input  logic          go_QR,
    input  qr_pkg::vec_t  x_vec,
    input  qr_pkg::vec_t  y_vec,
    output qr_pkg::elem_t dot
);

    qr_pkg::elem_t prod [qr_pkg::N_DIM];  // per lane product, truncated to 64 bits
    qr_pkg::elem_t sum;

    always_comb
    begin
        for (int i = 0; i < qr_pkg::N_DIM; i++)
        begin
            prod[i] = x_vec.lane[i] * y_vec.lane[i];  // signed, wraps like the model
        end
    end

    // two level adder tree
    always_comb
    begin
        sum = (prod[0] + prod[1]) + (prod[2] + prod[3]);
    end

    always_ff @(posedge clk_QR_g or negedge go_QR)
    begin
        if (!go_QR)
        begin
            dot <= '0;
        end
        else
        begin
            dot <= sum;  // no enable, follows operands every cycle
        end
    end

endmodule

//--- hdl/gs_sequencer.sv
`timescale 1ns/1ps

// classical gram-schmidt control
// u1 = a1, u_k = a_k - sum over j<k of proj(a_k on u_j), r_k = u_k . u_k
module gs_sequencer
(
    input  logic            clk_QR_g,
    input  logic            go_QR,
    input  logic            start,
    input  qr_pkg::in_mat_t a_mat,
    input  qr_pkg::elem_t   dot,
    input  qr_pkg::vec_t    proj_vec,
    input  logic            proj_done,
    output qr_pkg::vec_t    x_vec,
    output qr_pkg::vec_t    y_vec,
    output logic            proj_start,
    output qr_pkg::elem_t   coef,
    output qr_pkg::vec_t    basis,
    output qr_pkg::elem_t   norm,
    output logic            busy,
    output logic            done,
    output qr_pkg::mat_t    u_mat,
    output qr_pkg::norm_t   norms
);

    typedef enum logic [2:0]
    {
        S_IDLE,       // wait for start
        S_NORM,       // u_k . u_k on the dot unit
        S_NORM_WAIT,  // r_k valid
        S_DOT,        // u_j . a_k on the dot unit
        S_PSTART,     // coefficient valid, launch projection
        S_PWAIT       // divider lanes running
    } state_t;

    state_t                   state;
    logic [qr_pkg::IDX_W-1:0] k;         // column being built
    logic [qr_pkg::IDX_W-1:0] j;         // basis being projected out
    qr_pkg::mat_t             a_ext;     // A widened to 64 bits
    qr_pkg::mat_t             a_reg;
    qr_pkg::vec_t             work;      // a_k minus projections so far
    qr_pkg::vec_t             work_sub;  // work with current projection removed

    // sign extension of the input matrix
    always_comb
    begin
        for (int c = 0; c < qr_pkg::N_DIM; c++)
        begin
            for (int i = 0; i < qr_pkg::N_DIM; i++)
            begin
                a_ext.col[c].lane[i] = qr_pkg::elem_t'(a_mat.col[c].lane[i]);
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < qr_pkg::N_DIM; i++)
        begin
            work_sub.lane[i] = work.lane[i] - proj_vec.lane[i];
        end
    end

    // operand steering
    always_comb
    begin
        proj_start = (state == S_PSTART);
        coef       = dot;              // dot of S_DOT lands in S_PSTART
        basis      = u_mat.col[j];
        norm       = norms.r[j];
        if (state == S_NORM)
        begin
            x_vec = u_mat.col[k];
            y_vec = u_mat.col[k];
        end
        else
        begin
            x_vec = u_mat.col[j];
            y_vec = a_reg.col[k];
        end
    end

    // A and the working column
    always_ff @(posedge clk_QR_g)
    begin
        if (state == S_IDLE && start)
        begin
            a_reg <= a_ext;
        end
        if (state == S_NORM_WAIT)
        begin
            work <= a_reg.col[k + 1'b1];   // next column starts as a_k
        end
        else if (state == S_PWAIT && proj_done)
        begin
            work <= work_sub;
        end
    end

    always_ff @(posedge clk_QR_g or negedge go_QR)
    begin
        if (!go_QR)
        begin
            state <= S_IDLE;
            k     <= '0;
            j     <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
            u_mat <= '0;
            norms <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)                       // ignored while busy
                    begin
                        u_mat.col[0] <= a_ext.col[0];  // u1 = a1
                        k            <= '0;
                        busy         <= 1'b1;
                        state        <= S_NORM;
                    end
                end
                S_NORM:
                begin
                    state <= S_NORM_WAIT;
                end
                S_NORM_WAIT:
                begin
                    norms.r[k] <= dot;
                    if (int'(k) == qr_pkg::N_DIM - 1)
                    begin
                        busy  <= 1'b0;               // falls with done
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                    else
                    begin
                        k     <= k + 1'b1;
                        j     <= '0;
                        state <= S_DOT;
                    end
                end
                S_DOT:
                begin
                    state <= S_PSTART;
                end
                S_PSTART:
                begin
                    state <= S_PWAIT;
                end
                S_PWAIT:
                begin
                    if (proj_done)
                    begin
                        if (j == k - 1'b1)           // last basis for this column
                        begin
                            u_mat.col[k] <= work_sub;
                            state        <= S_NORM;
                        end
                        else
                        begin
                            j     <= j + 1'b1;
                            state <= S_DOT;
                        end
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/projection_unit.sv
`timescale 1ns/1ps

// projection of a column on one basis vector
// lane i = (coef * basis[i]) / norm, four dividers in parallel
// proj_done comes DIV_CYCLES+1 cycles after proj_start
module projection_unit
(
    input  logic          clk_QR_g,
    input  logic          go_QR,
    input  logic          proj_start,
    input  qr_pkg::elem_t coef,
    input  qr_pkg::vec_t  basis,
    input  qr_pkg::elem_t norm,
    output qr_pkg::vec_t  proj_vec,
    output logic          proj_done
);

    logic                     div_start;     // proj_start delayed past the multipliers
    qr_pkg::vec_t             numer_vec;     // one numerator per lane
    qr_pkg::elem_t            denom_q;       // shared by all lanes
    qr_pkg::elem_t            lane_quot [qr_pkg::N_DIM];
    logic [qr_pkg::N_DIM-1:0] lane_done;

    always_ff @(posedge clk_QR_g or negedge go_QR)
    begin
        if (!go_QR)
        begin
            div_start <= 1'b0;
        end
        else
        begin
            div_start <= proj_start;
        end
    end

    // numerators and denominator captured with the start pulse
    always_ff @(posedge clk_QR_g)
    begin
        if (proj_start)
        begin
            for (int i = 0; i < qr_pkg::N_DIM; i++)
            begin
                numer_vec.lane[i] <= coef * basis.lane[i];  // truncated to 64 bits
            end
            denom_q <= norm;
        end
    end

    for (genvar i = 0; i < qr_pkg::N_DIM; i++)
    begin : g_lane
        seq_divider i_div
        (
            .clk_QR_g (clk_QR_g),
            .go_QR    (go_QR),
            .start    (div_start),
            .numer    (numer_vec.lane[i]),
            .denom    (denom_q),
            .quot     (lane_quot[i]),
            .done     (lane_done[i])
        );
    end

    // quotients hold in the dividers until the next start
    always_comb
    begin
        for (int i = 0; i < qr_pkg::N_DIM; i++)
        begin
            proj_vec.lane[i] = lane_quot[i];
        end
    end

    assign proj_done = &lane_done;  // all lanes finish on the same edge

endmodule

//--- hdl/qr_orth_top.sv
`timescale 1ns/1ps

// gram-schmidt orthogonalization of a 4x4 integer matrix
module qr_orth_top
(
    input  logic            clk_QR_g,
    input  logic            go_QR,
    input  logic            start,
    input  qr_pkg::in_mat_t a_mat,
    output logic            busy,
    output logic            done,
    output qr_pkg::mat_t    u_mat,
    output qr_pkg::norm_t   norms
);

    qr_pkg::vec_t  x_vec;       // dot unit operands
    qr_pkg::vec_t  y_vec;
    qr_pkg::elem_t dot;
    logic          proj_start;
    qr_pkg::elem_t coef;
    qr_pkg::vec_t  basis;
    qr_pkg::elem_t norm;
    qr_pkg::vec_t  proj_vec;
    logic          proj_done;

    gs_sequencer i_seq
    (
        .clk_QR_g   (clk_QR_g),
        .go_QR      (go_QR),
        .start      (start),
        .a_mat      (a_mat),
        .dot        (dot),
        .proj_vec   (proj_vec),
        .proj_done  (proj_done),
        .x_vec      (x_vec),
        .y_vec      (y_vec),
        .proj_start (proj_start),
        .coef       (coef),
        .basis      (basis),
        .norm       (norm),
        .busy       (busy),
        .done       (done),
        .u_mat      (u_mat),
        .norms      (norms)
    );

    dot4_unit i_dot
    (
        .clk_QR_g (clk_QR_g),
        .go_QR    (go_QR),
        .x_vec    (x_vec),
        .y_vec    (y_vec),
        .dot      (dot)
    );

    projection_unit i_proj
    (
        .clk_QR_g   (clk_QR_g),
        .go_QR      (go_QR),
        .proj_start (proj_start),
        .coef       (coef),
        .basis      (basis),
        .norm       (norm),
        .proj_vec   (proj_vec),
        .proj_done  (proj_done)
    );

endmodule

//--- hdl/qr_pkg.sv
package qr_pkg;

    // matrix order and widths
    localparam int N_DIM      = 4;
    localparam int IN_W       = 16;            // input element width
    localparam int ELEM_W     = 64;            // internal and result width

    // divider takes one load cycle, ELEM_W bit cycles and a sign fix cycle
    localparam int DIV_CYCLES = ELEM_W + 2;

    // counter widths
    localparam int IDX_W      = $clog2(N_DIM);    // row / column index
    localparam int DIV_CNT_W  = $clog2(ELEM_W);   // divider bit counter

    // scalar types
    typedef logic signed [IN_W-1:0]   in_elem_t;
    typedef logic signed [ELEM_W-1:0] elem_t;

    // one input column, lane i holds row i
    typedef struct packed
    {
        in_elem_t [N_DIM-1:0] lane;
    } in_vec_t;

    // one internal column, same lane order
    typedef struct packed
    {
        elem_t [N_DIM-1:0] lane;
    } vec_t;

    // input matrix by columns
    // col[0] is c1 ... col[3] is c4
    typedef struct packed
    {
        in_vec_t [N_DIM-1:0] col;
    } in_mat_t;

    // internal matrix by columns, col[0] is u1
    typedef struct packed
    {
        vec_t [N_DIM-1:0] col;
    } mat_t;

    // squared norms, r[0] is r1
    typedef struct packed
    {
        elem_t [N_DIM-1:0] r;
    } norm_t;

endpackage

//--- hdl/seq_divider.sv
`timescale 1ns/1ps

// restoring divider on magnitudes, one quotient bit per cycle
// sign applied at the end so the quotient truncates toward zero
// zero denominator returns zero with the normal latency
module seq_divider
(
    input  logic          clk_QR_g,
    input  logic          go_QR,
    input  logic          start,
    input  qr_pkg::elem_t numer,
    input  qr_pkg::elem_t denom,
    output qr_pkg::elem_t quot,
    output logic          done
);

    logic                         running;  // bit cycles in progress
    logic                         fin;      // last bit taken, sign fix next
    logic [qr_pkg::DIV_CNT_W-1:0] cnt;      // bits taken so far
    logic [qr_pkg::ELEM_W-1:0]    mag_n;    // dividend bits shift out, quotient shifts in
    logic [qr_pkg::ELEM_W-1:0]    mag_d;
    logic [qr_pkg::ELEM_W-1:0]    rem;      // partial remainder, always below mag_d
    logic                         neg_q;
    logic                         zero_d;
    logic [qr_pkg::ELEM_W:0]      shifted;  // remainder with next dividend bit
    logic [qr_pkg::ELEM_W:0]      trial;    // msb set means subtract failed

    assign shifted = {rem, mag_n[qr_pkg::ELEM_W-1]};
    assign trial   = shifted - {1'b0, mag_d};

    // control
    always_ff @(posedge clk_QR_g or negedge go_QR)
    begin
        if (!go_QR)
        begin
            running <= 1'b0;
            fin     <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= fin;  // one cycle after the sign fix is loaded
            fin  <= 1'b0;
            if (start)
            begin
                running <= 1'b1;
                cnt     <= '0;
            end
            else if (running)
            begin
                cnt <= cnt + 1'b1;
                if (int'(cnt) == qr_pkg::ELEM_W - 1)
                begin
                    running <= 1'b0;
                    fin     <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk_QR_g)
    begin
        if (start)
        begin
            // -(-2**63) keeps the bit pattern, which is right as a magnitude
            mag_n  <= numer[qr_pkg::ELEM_W-1] ? -numer : numer;
            mag_d  <= denom[qr_pkg::ELEM_W-1] ? -denom : denom;
            rem    <= '0;
            neg_q  <= numer[qr_pkg::ELEM_W-1] ^ denom[qr_pkg::ELEM_W-1];
            zero_d <= (denom == '0);
        end
        else if (running)
        begin
            if (!trial[qr_pkg::ELEM_W])
            begin
                rem   <= trial[qr_pkg::ELEM_W-1:0];               // subtract fits
                mag_n <= {mag_n[qr_pkg::ELEM_W-2:0], 1'b1};
            end
            else
            begin
                rem   <= shifted[qr_pkg::ELEM_W-1:0];             // restore
                mag_n <= {mag_n[qr_pkg::ELEM_W-2:0], 1'b0};
            end
        end
        if (fin)
        begin
            quot <= zero_d ? '0 : (neg_q ? -mag_n : mag_n);
        end
    end

endmodule

//--- verification/qr_stimulus.txt
# code, then A by columns as 16 bit hex (a11 a21 a31 a41 a12 ... a44)
# next four lines u1 to u4 rows 0 to 3, last line r1 to r4, all 64 bit hex
# codes 1 diagonal, 2 general, 3 dependent columns, 4 start while busy, 5 reset midway
# diagonal 3 -5 7 2
1 0003 0000 0000 0000 0000 fffb 0000 0000 0000 0000 0007 0000 0000 0000 0000 0002
0000000000000003 0000000000000000 0000000000000000 0000000000000000
0000000000000000 fffffffffffffffb 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000007 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000002
0000000000000009 0000000000000019 0000000000000031 0000000000000004
# small mixed signs, -8/6 truncates to -1
2 0001 0002 ffff 0000 0003 ffff 0002 0001 fffe 0004 0001 0003 0005 0000 fffd 0002
0000000000000001 0000000000000002 ffffffffffffffff 0000000000000000
0000000000000003 ffffffffffffffff 0000000000000002 0000000000000001
ffffffffffffffff 0000000000000003 0000000000000001 0000000000000003
0000000000000002 fffffffffffffffe fffffffffffffffd 0000000000000002
0000000000000006 000000000000000f 0000000000000014 0000000000000015
# wider values, many negative quotients
2 000a ffec 001e 0005 fff9 0064 0004 ffc4 012c 0001 ffce 0014 fc18 00c8 000f 0009
000000000000000a ffffffffffffffec 000000000000001e 0000000000000005
0000000000000008 0000000000000045 0000000000000033 ffffffffffffffcb
0000000000000121 000000000000001e ffffffffffffffb2 000000000000000a
fffffffffffffffc 0000000000000040 0000000000000019 0000000000000076
0000000000000591 00000000000027fb 00000000000161ed 00000000000048e5
# column 2 is -2 times column 1, u2 and r2 zero
3 0001 ffff 0002 0003 fffe 0002 fffc fffa 0004 0000 ffff 0002 0000 0005 0001 fffd
0000000000000001 ffffffffffffffff 0000000000000002 0000000000000003
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000004 0000000000000000 fffffffffffffffe 0000000000000001
0000000000000000 0000000000000005 0000000000000002 ffffffffffffffff
000000000000000f 0000000000000000 0000000000000015 000000000000001e
# second start with the inverted matrix while busy
4 000a ffec 001e 0005 fff9 0064 0004 ffc4 012c 0001 ffce 0014 fc18 00c8 000f 0009
000000000000000a ffffffffffffffec 000000000000001e 0000000000000005
0000000000000008 0000000000000045 0000000000000033 ffffffffffffffcb
0000000000000121 000000000000001e ffffffffffffffb2 000000000000000a
fffffffffffffffc 0000000000000040 0000000000000019 0000000000000076
0000000000000591 00000000000027fb 00000000000161ed 00000000000048e5
# reset partway, then the same matrix again
5 0001 0002 ffff 0000 0003 ffff 0002 0001 fffe 0004 0001 0003 0005 0000 fffd 0002
0000000000000001 0000000000000002 ffffffffffffffff 0000000000000000
0000000000000003 ffffffffffffffff 0000000000000002 0000000000000001
ffffffffffffffff 0000000000000003 0000000000000001 0000000000000003
0000000000000002 fffffffffffffffe fffffffffffffffd 0000000000000002
0000000000000006 000000000000000f 0000000000000014 0000000000000015

//--- verification/tb_qr_orth.sv
`timescale 1ns/1ps

// testbench for the gram-schmidt orthogonalizer
// tests come from verification/qr_stimulus.txt with one record per test
module tb_qr_orth;

    // worst case start to done for the watchdog
    localparam int LAT_BOUND = 25 + 6 * (qr_pkg::DIV_CYCLES + 2);
    localparam int MAX_TESTS = 32;
    localparam int RESET_RUN = 40;    // cycles into a run before go_QR drops

    logic            clk_QR_g;
    logic            go_QR;
    logic            start;
    qr_pkg::in_mat_t a_mat;
    logic            busy;
    logic            done;
    qr_pkg::mat_t    u_mat;
    qr_pkg::norm_t   norms;

    // test table
    int              test_code [MAX_TESTS];
    qr_pkg::in_mat_t test_a    [MAX_TESTS];
    qr_pkg::mat_t    test_u    [MAX_TESTS];
    qr_pkg::norm_t   test_r    [MAX_TESTS];
    int              n_tests;

    int         err_cnt;
    int         pass_cnt;
    int         fail_cnt;
    int         cycle_cnt;
    int         cycle_limit = LAT_BOUND + 200;   // raised once the file is read
    logic [7:0] lfsr;                            // idle gap source

    qr_orth_top i_dut
    (
        .clk_QR_g (clk_QR_g),
        .go_QR    (go_QR),
        .start    (start),
        .a_mat    (a_mat),
        .busy     (busy),
        .done     (done),
        .u_mat    (u_mat),
        .norms    (norms)
    );

    // 8 ns clock
    initial
    begin
        clk_QR_g = 1'b0;
        forever #4 clk_QR_g = ~clk_QR_g;
    end

    // watchdog
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk_QR_g);
            cycle_cnt++;
        end
        $display("timeout: the DUT never finished, stopped after %0d cycles", cycle_cnt);
        $display("sim failed");
        $finish;
    end

    // galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    // 0 to 7 idle cycles with one lfsr step per bit
    task automatic pick_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 3; b++)
        begin
            lfsr = lfsr_next(lfsr);
            gap  = (gap << 1) | lfsr[0];
        end
    endtask

    function automatic string test_name(input int code);
        case (code)
            1:       return "diagonal";
            2:       return "general";
            3:       return "dependent columns";
            4:       return "start while busy";
            5:       return "reset midway";
            default: return "unknown";
        endcase
    endfunction

    // drive and sample 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_QR_g);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s: got %0h, expected %0h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic compare_results(input qr_pkg::mat_t exp_u, input qr_pkg::norm_t exp_r);
        for (int c = 0; c < qr_pkg::N_DIM; c++)
        begin
            for (int i = 0; i < qr_pkg::N_DIM; i++)
            begin
                check_value($sformatf("u_mat.col[%0d].lane[%0d]", c, i),
                            u_mat.col[c].lane[i], exp_u.col[c].lane[i]);
            end
            check_value($sformatf("norms.r[%0d]", c), norms.r[c], exp_r.r[c]);
        end
    endtask

    // each record holds the code, A by columns, U one column per line and r1 to r4
    task automatic load_stimulus(output bit ok);
        int          fd;
        int          code;
        bit          bad;
        string       tok;
        string       rest;
        logic [63:0] v;
        ok      = 1'b0;
        bad     = 1'b0;
        n_tests = 0;
        code    = 0;
        fd = $fopen("verification/qr_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open verification/qr_stimulus.txt");
        end
        else
        begin
            while (!bad && $fscanf(fd, "%s", tok) == 1)
            begin
                if (tok[0] == "#")
                begin
                    if ($fgets(rest, fd) == 0)   // skip comment line
                        bad = 1'b1;
                end
                else if (n_tests == MAX_TESTS)
                begin
                    bad = 1'b1;
                end
                else
                begin
                    if ($sscanf(tok, "%h", code) != 1)
                        bad = 1'b1;
                    test_code[n_tests] = code;
                    for (int c = 0; c < qr_pkg::N_DIM; c++)
                    begin
                        for (int i = 0; i < qr_pkg::N_DIM; i++)
                        begin
                            if ($fscanf(fd, "%h", v) != 1)
                                bad = 1'b1;
                            test_a[n_tests].col[c].lane[i] = v[qr_pkg::IN_W-1:0];
                        end
                    end
                    for (int c = 0; c < qr_pkg::N_DIM; c++)
                    begin
                        for (int i = 0; i < qr_pkg::N_DIM; i++)
                        begin
                            if ($fscanf(fd, "%h", v) != 1)
                                bad = 1'b1;
                            test_u[n_tests].col[c].lane[i] = v;
                        end
                    end
                    for (int c = 0; c < qr_pkg::N_DIM; c++)
                    begin
                        if ($fscanf(fd, "%h", v) != 1)
                            bad = 1'b1;
                        test_r[n_tests].r[c] = v;
                    end
                    n_tests++;
                end
            end
            $fclose(fd);
            if (bad)
                $display("stimulus file is malformed or holds too many tests");
            ok = !bad && (n_tests > 0);
        end
    endtask

    // one computation with busy and done followed every cycle
    task automatic run_matrix(input int t, input bit second_start);
        a_mat = test_a[t];
        start = 1'b1;
        tick();
        start = 1'b0;
        check_value("busy", busy, 1'b1);   // raised on the start edge
        check_value("done", done, 1'b0);
        if (second_start)
        begin
            a_mat = ~test_a[t];            // other matrix that must be ignored
            start = 1'b1;
            tick();
            start = 1'b0;
        end
        while (done !== 1'b1)
        begin
            check_value("busy", busy, 1'b1);
            tick();
        end
        check_value("busy", busy, 1'b0);   // falls with done
        tick();
        check_value("done", done, 1'b0);   // single cycle pulse
        compare_results(test_u[t], test_r[t]);
    endtask

    // drop go_QR partway through a run
    task automatic reset_midway(input int t);
        a_mat = test_a[t];
        start = 1'b1;
        tick();
        start = 1'b0;
        repeat (RESET_RUN) tick();
        check_value("busy", busy, 1'b1);   // still computing
        go_QR = 1'b0;
        #1;
        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);
        compare_results('0, '0);           // results cleared
        repeat (2) tick();
        go_QR = 1'b1;
        tick();
    endtask

    initial
    begin
        bit ok;
        int gap;
        int errs_before;
        int n_runs;
        go_QR    = 1'b0;
        start    = 1'b0;
        a_mat    = '0;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        lfsr     = 8'd71;
        load_stimulus(ok);
        if (!ok)
        begin
            $display("no tests could be read from the stimulus file");
        end
        else
        begin
            n_runs = n_tests;
            for (int t = 0; t < n_tests; t++)
            begin
                if (test_code[t] == 5)
                    n_runs++;                // reset test runs twice
            end
            cycle_limit = n_runs * LAT_BOUND + 200;
            repeat (16) tick();              // reset held 16 cycles
            go_QR = 1'b1;
            for (int t = 0; t < n_tests; t++)
            begin
                errs_before = err_cnt;
                pick_gap(gap);
                repeat (gap) tick();
                case (test_code[t])
                    4:
                    begin
                        run_matrix(t, 1'b1);
                    end
                    5:
                    begin
                        reset_midway(t);
                        run_matrix(t, 1'b0);
                    end
                    default:
                    begin
                        run_matrix(t, 1'b0);
                    end
                endcase
                if (err_cnt == errs_before)
                begin
                    pass_cnt++;
                    $display("test %0d (%s): ok", t, test_name(test_code[t]));
                end
                else
                begin
                    fail_cnt++;
                    $display("test %0d (%s): %0d mismatches", t, test_name(test_code[t]),
                             err_cnt - errs_before);
                end
            end
            $display("%0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
        end
        if (ok && fail_cnt == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
